/* agent/cmd_decode.sv */
// command packet decoder: masked address, suppression and response decisions
`timescale 1ns/100ps
`include "agent_macros.svh"

module cmd_decode (
   input  pkt_pkg::cmd_pkt_t cp_data,
   output pkt_pkg::addr_t    m0_address,
   output logic              suppress,
   output logic              needs_synth,
   output logic              needs_response
);

   logic byteen_any;
   logic nonposted_write;
   logic suppress_read;

   // --------------------------------------------------------------------------
   // address alignment
   // --------------------------------------------------------------------------
   // the interconnect may hand over a byte address inside the data word
   // the slave only ever sees whole words, so the low bits are forced to zero
   // and the byte enables alone select the bytes
   assign m0_address = {cp_data.addr[`AGENT_ADDR_W-1:`AGENT_MASK_BITS],
                        {`AGENT_MASK_BITS{1'b0}}};

   // --------------------------------------------------------------------------
   // suppression
   // --------------------------------------------------------------------------
   // a command with no byte enabled touches nothing in the slave
   // it is never passed on, reads and writes alike
   assign byteen_any = |cp_data.byteen;
   assign suppress   = ~byteen_any;

   // a suppressed read still owes its master a response
   assign suppress_read = cp_data.read & suppress;

   // --------------------------------------------------------------------------
   // response decisions
   // --------------------------------------------------------------------------
   // posted writes are fire and forget
   assign nonposted_write = cp_data.write & ~cp_data.posted;

   // every read and every non-posted write takes a pending-queue slot
   assign needs_response = cp_data.read | nonposted_write;

   // the slave returns nothing for writes, so every non-posted write gets a
   // made-up OKAY, and a suppressed read never reaches the slave and gets
   // the same treatment
   assign needs_synth = suppress_read | nonposted_write;

endmodule

/* agent/cmd_execute.sv */
// slave command issue, command back-pressure and pending-queue push
`timescale 1ns/100ps

module cmd_execute (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cp_valid,
   input  pkt_pkg::cmd_pkt_t      cp_data,
   output logic                   cp_ready,
   input  logic                   suppress,
   input  logic                   needs_synth,
   input  logic                   needs_response,
   output logic                   m0_read,
   output logic                   m0_write,
   input  logic                   m0_waitrequest,
   input  logic                   pend_full,
   output logic                   pend_push,
   output slave_pkg::pend_entry_t pend_data
);

   logic slave_ok;
   logic room;
   logic accept;

   // --------------------------------------------------------------------------
   // back-pressure
   // --------------------------------------------------------------------------
   // the slave stalls only commands that actually go to it
   assign slave_ok = ~m0_waitrequest | suppress;

   // a full pending queue holds every command, even those needing no
   // response, which keeps the ready path short
   // every accepted read holds a pending slot, so this also bounds the
   // reads outstanding at the slave
   assign room = ~pend_full;

   assign cp_ready = slave_ok & room;
   assign accept   = cp_valid & cp_ready;

   // reads and writes follow cp_valid in the same cycle
   assign m0_read  = cp_valid & cp_data.read & ~suppress & room;
   assign m0_write = cp_valid & cp_data.write & ~suppress & room;

   // --------------------------------------------------------------------------
   // pending-queue push
   // --------------------------------------------------------------------------
   // the entry goes in at the acceptance edge so response order follows
   // command order
   assign pend_push         = accept & needs_response;
   assign pend_data.synth   = needs_synth;
   assign pend_data.read    = cp_data.read;
   assign pend_data.write   = cp_data.write;
   assign pend_data.byteen  = cp_data.byteen;
   assign pend_data.src_id  = cp_data.src_id;
   assign pend_data.dest_id = cp_data.dest_id;

endmodule

/* agent/resp_result.sv */
// response builder: pairs pending entries with read data and forms response packets
`timescale 1ns/100ps

module resp_result (
   input  logic                    pend_empty,
   input  slave_pkg::pend_entry_t  pend_head,
   output logic                    pend_pop,
   input  logic                    rdata_empty,
   input  slave_pkg::rdata_entry_t rdata_head,
   output logic                    rdata_pop,
   output logic                    rp_valid,
   input  logic                    rp_ready,
   output pkt_pkg::rsp_pkt_t       rp_data
);

   logic data_ready;
   logic take;

   // --------------------------------------------------------------------------
   // response valid
   // --------------------------------------------------------------------------
   // the oldest pending entry decides what is sent next
   // a synthesized entry can leave at once, a slave read has to wait for its
   // beat at the head of the read-data queue
   assign data_ready = pend_head.synth | ~rdata_empty;
   assign rp_valid   = ~pend_empty & data_ready;

   // both heads stay put until the response is taken, so rp_data holds
   // while rp_ready is low
   assign take      = rp_valid & rp_ready;
   assign pend_pop  = take;

   // synthesized responses never consumed read data
   assign rdata_pop = take & ~pend_head.synth;

   // --------------------------------------------------------------------------
   // response packet
   // --------------------------------------------------------------------------
   always_comb begin
      rp_data.byteen = pend_head.byteen;
      rp_data.read   = pend_head.read;
      rp_data.write  = pend_head.write;

      // swap the ids so the response routes back to the issuing master
      rp_data.src_id  = pend_head.dest_id;
      rp_data.dest_id = pend_head.src_id;

      if (pend_head.synth) begin
         // write responses and suppressed reads carry no data
         rp_data.data   = '0;
         rp_data.status = slave_pkg::OKAY;
      end else begin
         // slave read, data and status as captured with readdatavalid
         rp_data.data   = rdata_head.data;
         rp_data.status = rdata_head.status;
      end
   end

endmodule

/* agent/slave_agent.sv */
// slave agent top level: decode, execute, pending and read-data queues, result
`timescale 1ns/100ps
`include "agent_macros.svh"

module slave_agent (
   input  logic              clk,
   input  logic              reset,

   // command packets from the interconnect
   input  logic              cp_valid,
   output logic              cp_ready,
   input  pkt_pkg::cmd_pkt_t cp_data,

   // Avalon-style slave port
   output pkt_pkg::addr_t    m0_address,
   output pkt_pkg::be_t      m0_byteenable,
   output logic              m0_read,
   output logic              m0_write,
   output pkt_pkg::data_t    m0_writedata,
   input  logic              m0_waitrequest,
   input  pkt_pkg::data_t    m0_readdata,
   input  logic              m0_readdatavalid,
   input  logic [1:0]        m0_response,

   // response packets to the interconnect
   output logic              rp_valid,
   input  logic              rp_ready,
   output pkt_pkg::rsp_pkt_t rp_data
);

   logic                    suppress;
   logic                    needs_synth;
   logic                    needs_response;
   logic                    pend_push;
   logic                    pend_pop;
   logic                    pend_empty;
   logic                    pend_full;
   slave_pkg::pend_entry_t  pend_data;
   slave_pkg::pend_entry_t  pend_head;
   logic                    rdata_pop;
   logic                    rdata_empty;
   slave_pkg::rdata_entry_t rdata_in;
   slave_pkg::rdata_entry_t rdata_head;

   // data and byte enables pass straight from the packet to the slave
   assign m0_byteenable = cp_data.byteen;
   assign m0_writedata  = cp_data.data;

   // every returned read beat is captured with its status
   assign rdata_in.data   = m0_readdata;
   assign rdata_in.status = slave_pkg::resp_status_t'(m0_response);

   // --------------------------------------------------------------------------
   // command side
   // --------------------------------------------------------------------------
   cmd_decode u_decode (
      .cp_data        (cp_data),
      .m0_address     (m0_address),
      .suppress       (suppress),
      .needs_synth    (needs_synth),
      .needs_response (needs_response)
   );

   cmd_execute u_execute (
      .clk            (clk),
      .reset          (reset),
      .cp_valid       (cp_valid),
      .cp_data        (cp_data),
      .cp_ready       (cp_ready),
      .suppress       (suppress),
      .needs_synth    (needs_synth),
      .needs_response (needs_response),
      .m0_read        (m0_read),
      .m0_write       (m0_write),
      .m0_waitrequest (m0_waitrequest),
      .pend_full      (pend_full),
      .pend_push      (pend_push),
      .pend_data      (pend_data)
   );

   // --------------------------------------------------------------------------
   // queues
   // --------------------------------------------------------------------------
   sync_fifo #(
      .entry_t (slave_pkg::pend_entry_t),
      .depth   (`AGENT_PEND_DEPTH)
   ) pend_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (pend_push),
      .push_data (pend_data),
      .pop       (pend_pop),
      .pop_data  (pend_head),
      .empty     (pend_empty),
      .full      (pend_full)
   );

   // outstanding reads never exceed the pending depth, so this queue never fills
   sync_fifo #(
      .entry_t (slave_pkg::rdata_entry_t),
      .depth   (`AGENT_PEND_DEPTH)
   ) rdata_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (m0_readdatavalid),
      .push_data (rdata_in),
      .pop       (rdata_pop),
      .pop_data  (rdata_head),
      .empty     (rdata_empty),
      .full      ()
   );

   // --------------------------------------------------------------------------
   // response side
   // --------------------------------------------------------------------------
   resp_result u_result (
      .pend_empty  (pend_empty),
      .pend_head   (pend_head),
      .pend_pop    (pend_pop),
      .rdata_empty (rdata_empty),
      .rdata_head  (rdata_head),
      .rdata_pop   (rdata_pop),
      .rp_valid    (rp_valid),
      .rp_ready    (rp_ready),
      .rp_data     (rp_data)
   );

endmodule

/* common/agent_macros.svh */
// width, depth and address mask macros for the slave agent
`ifndef AGENT_MACROS_SVH
`define AGENT_MACROS_SVH

// --------------------------------------------------------------------------
// data path widths
// --------------------------------------------------------------------------

// width of the slave data bus in bits
`define AGENT_DATA_W 32

// byte address width carried in the command packet
`define AGENT_ADDR_W 32

// width of the source and destination ids
`define AGENT_ID_W 3

// one symbol is one byte on this interconnect
`define AGENT_SYMBOL_W 8

// one byte enable per symbol of the data word
`define AGENT_BE_W (`AGENT_DATA_W / `AGENT_SYMBOL_W)

// --------------------------------------------------------------------------
// queue sizing and address alignment
// --------------------------------------------------------------------------

// both internal queues share this depth, which also bounds outstanding reads
`define AGENT_PEND_DEPTH 4

// low address bits cleared to reach the full data word boundary
`define AGENT_MASK_BITS 2

`endif

/* common/pkt_pkg.sv */
// interconnect packet types: field types, command packet and response packet
`include "agent_macros.svh"

package pkt_pkg;

   // --------------------------------------------------------------------------
   // field types shared by both packet directions
   // --------------------------------------------------------------------------
   typedef logic [`AGENT_DATA_W-1:0] data_t;
   typedef logic [`AGENT_ADDR_W-1:0] addr_t;
   typedef logic [`AGENT_BE_W-1:0]   be_t;
   typedef logic [`AGENT_ID_W-1:0]   id_t;

   // --------------------------------------------------------------------------
   // command packet from the interconnect
   // --------------------------------------------------------------------------
   // the address is a byte address and may be unaligned
   // posted only matters for writes and means no response is wanted
   typedef struct packed {
      data_t data;
      be_t   byteen;
      addr_t addr;
      logic  read;
      logic  write;
      logic  posted;
      id_t   src_id;
      id_t   dest_id;
   } cmd_pkt_t;

   // --------------------------------------------------------------------------
   // response packet back to the interconnect
   // --------------------------------------------------------------------------
   // src_id and dest_id are already swapped relative to the command, so the
   // response routes back to the master that issued it
   typedef struct packed {
      data_t                   data;
      be_t                     byteen;
      logic                    read;
      logic                    write;
      id_t                     src_id;
      id_t                     dest_id;
      slave_pkg::resp_status_t status;
   } rsp_pkt_t;

endpackage

/* common/slave_pkg.sv */
// slave side types: response status enum, read-data queue entry, pending-response entry
`include "agent_macros.svh"

package slave_pkg;

   // --------------------------------------------------------------------------
   // response status as returned on m0_response and sent in response packets
   // --------------------------------------------------------------------------
   typedef enum logic [1:0] {
      OKAY     = 2'd0,
      RESERVED = 2'd1,
      SLVERR   = 2'd2,
      DECERR   = 2'd3
   } resp_status_t;

   // one returned read beat, captured on m0_readdatavalid
   typedef struct packed {
      logic [`AGENT_DATA_W-1:0] data;
      resp_status_t             status;
   } rdata_entry_t;

   // --------------------------------------------------------------------------
   // one command still owed a response, kept in acceptance order
   // --------------------------------------------------------------------------
   // synth set means the agent makes up the response itself and no read data
   // is waited for
   typedef struct packed {
      logic                   synth;
      logic                   read;
      logic                   write;
      logic [`AGENT_BE_W-1:0] byteen;
      logic [`AGENT_ID_W-1:0] src_id;
      logic [`AGENT_ID_W-1:0] dest_id;
   } pend_entry_t;

endpackage

/* run.sh */
#!/bin/sh
# build the slave agent testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module slave_agent_tb \
   -f vlog.f -o slave_agent_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/slave_agent_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST OK" sim.log || exit 1

/* sim/slave_agent_checker.sv */
// concurrent protocol assertions for the slave agent, bound to its top level
`timescale 1ns/100ps

module slave_agent_checker (
   input logic              clk,
   input logic              reset,
   input logic              m0_read,
   input logic              m0_write,
   input logic              m0_waitrequest,
   input pkt_pkg::addr_t    m0_address,
   input logic              rp_valid,
   input logic              rp_ready,
   input pkt_pkg::rsp_pkt_t rp_data
);

   // failures seen so far, read by the testbench for its closing report
   int fail_count = 0;

   // a single-beat slave never sees a read and a write in the same cycle
   read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(m0_read && m0_write))
      else begin
         $error("m0_read and m0_write are high in the same cycle");
         fail_count++;
      end

   // a stalled response has to hold its contents until it is taken
   response_stable: assert property (@(posedge clk) disable iff (reset)
      rp_valid && !rp_ready |=> rp_valid && $stable(rp_data))
      else begin
         $error("rp_data changed while the response was stalled");
         fail_count++;
      end

   // the slave may keep a transfer waiting, the address has to stay put
   address_stable: assert property (@(posedge clk) disable iff (reset)
      (m0_read || m0_write) && m0_waitrequest |=> $stable(m0_address))
      else begin
         $error("m0_address changed while the transfer waited on m0_waitrequest");
         fail_count++;
      end

endmodule

bind slave_agent slave_agent_checker checker_inst (
   .clk            (clk),
   .reset          (reset),
   .m0_read        (m0_read),
   .m0_write       (m0_write),
   .m0_waitrequest (m0_waitrequest),
   .m0_address     (m0_address),
   .rp_valid       (rp_valid),
   .rp_ready       (rp_ready),
   .rp_data        (rp_data)
);

/* sim/slave_agent_tb.sv */
// slave agent testbench: command table, slave memory model, response checks and report
`timescale 1ns/100ps
`include "agent_macros.svh"

module slave_agent_tb;

   // rows from this index on run with random rp_ready
   localparam int mixed_first = 11;

   // one table row holds a command and the response it should produce
   typedef struct {
      string                    name;
      logic                     read;
      logic                     write;
      logic                     posted;
      logic [`AGENT_ADDR_W-1:0] addr;
      logic [`AGENT_DATA_W-1:0] data;
      logic [`AGENT_BE_W-1:0]   be;
      logic [`AGENT_ID_W-1:0]   src_id;
      logic [`AGENT_ID_W-1:0]   dest_id;
      logic                     exp_resp;
      logic [`AGENT_DATA_W-1:0] exp_data;
      logic [1:0]               exp_status;
   } row_t;

   logic              clk;
   logic              reset;
   logic              cp_valid;
   logic              cp_ready;
   pkt_pkg::cmd_pkt_t cp_data;
   pkt_pkg::addr_t    m0_address;
   pkt_pkg::be_t      m0_byteenable;
   logic              m0_read;
   logic              m0_write;
   pkt_pkg::data_t    m0_writedata;
   logic              m0_waitrequest;
   pkt_pkg::data_t    m0_readdata;
   logic              m0_readdatavalid;
   logic [1:0]        m0_response;
   logic              rp_valid;
   logic              rp_ready;
   pkt_pkg::rsp_pkt_t rp_data;

   row_t           rows[$];
   int             exp_q[$];
   pkt_pkg::data_t mem[16];
   pkt_pkg::data_t ret_data[$];
   logic [1:0]     ret_status[$];
   int             ret_due[$];
   int             slave_cycle;
   int             cycle;
   int             timeout_limit;
   int             err_count;
   int             check_count;
   logic           mixed;

   slave_agent UUT (.*);

   always #20 clk = ~clk;

   // --------------------------------------------------------------------------
   // table and checks
   // --------------------------------------------------------------------------
   function automatic void add_row(input string name, input logic rd, input logic wr,
                                   input logic posted, input logic [31:0] addr,
                                   input logic [31:0] data, input logic [3:0] be,
                                   input logic exp_resp, input logic [31:0] exp_data,
                                   input logic [1:0] exp_status);
      logic [2:0] src;
      logic [2:0] dst;
      src = 3'(rows.size());
      dst = 3'(rows.size() + 3);
      rows.push_back('{name, rd, wr, posted, addr, data, be, src, dst,
                       exp_resp, exp_data, exp_status});
   endfunction

   // memory word i starts as cafe0000 plus i times 11 hex, status 2 is SLVERR
   task automatic build_table();
      add_row("read word 3", 1'b1, 1'b0, 1'b0, 32'h0c, 32'h0, 4'hf, 1'b1, 32'hcafe0033, 2'd0);
      add_row("read unaligned 3", 1'b1, 1'b0, 1'b0, 32'h0e, 32'h0, 4'hf, 1'b1, 32'hcafe0033, 2'd0);
      add_row("read word 15", 1'b1, 1'b0, 1'b0, 32'h3c, 32'h0, 4'hf, 1'b1, 32'hcafe00ff, 2'd2);
      add_row("write bytes 0 2", 1'b0, 1'b1, 1'b0, 32'h14, 32'h11223344, 4'h5, 1'b1, 32'h0, 2'd0);
      add_row("read partial write", 1'b1, 1'b0, 1'b0, 32'h14, 32'h0, 4'hf, 1'b1, 32'hca220044, 2'd0);
      add_row("posted write 6", 1'b0, 1'b1, 1'b1, 32'h18, 32'hdeadbeef, 4'hf, 1'b0, 32'h0, 2'd0);
      add_row("read posted data", 1'b1, 1'b0, 1'b0, 32'h18, 32'h0, 4'hf, 1'b1, 32'hdeadbeef, 2'd0);
      add_row("read no byteen", 1'b1, 1'b0, 1'b0, 32'h08, 32'h0, 4'h0, 1'b1, 32'h0, 2'd0);
      add_row("write no byteen", 1'b0, 1'b1, 1'b0, 32'h1c, 32'h0, 4'h0, 1'b1, 32'h0, 2'd0);
      add_row("posted no byteen", 1'b0, 1'b1, 1'b1, 32'h1c, 32'hffffffff, 4'h0, 1'b0, 32'h0, 2'd0);
      add_row("read word 7 kept", 1'b1, 1'b0, 1'b0, 32'h1c, 32'h0, 4'hf, 1'b1, 32'hcafe0077, 2'd0);
      // mixed section with random rp_ready from here on
      add_row("mix write 1", 1'b0, 1'b1, 1'b0, 32'h04, 32'h01020304, 4'hf, 1'b1, 32'h0, 2'd0);
      add_row("mix read 1", 1'b1, 1'b0, 1'b0, 32'h04, 32'h0, 4'hf, 1'b1, 32'h01020304, 2'd0);
      add_row("mix posted 2", 1'b0, 1'b1, 1'b1, 32'h08, 32'ha0b0c0d0, 4'hc, 1'b0, 32'h0, 2'd0);
      add_row("mix read 2", 1'b1, 1'b0, 1'b0, 32'h0b, 32'h0, 4'hf, 1'b1, 32'ha0b00022, 2'd0);
      add_row("mix read no byteen", 1'b1, 1'b0, 1'b0, 32'h30, 32'h0, 4'h0, 1'b1, 32'h0, 2'd0);
      add_row("mix read 15", 1'b1, 1'b0, 1'b0, 32'h3f, 32'h0, 4'hf, 1'b1, 32'hcafe00ff, 2'd2);
      add_row("mix read 0", 1'b1, 1'b0, 1'b0, 32'h00, 32'h0, 4'hf, 1'b1, 32'hcafe0000, 2'd0);
      add_row("mix write 15", 1'b0, 1'b1, 1'b0, 32'h3c, 32'h55aa55aa, 4'h3, 1'b1, 32'h0, 2'd0);
      add_row("mix read 15 again", 1'b1, 1'b0, 1'b0, 32'h3c, 32'h0, 4'hf, 1'b1, 32'hcafe55aa, 2'd2);
      add_row("mix read 9", 1'b1, 1'b0, 1'b0, 32'h24, 32'h0, 4'hf, 1'b1, 32'hcafe0099, 2'd0);
      add_row("mix read 3", 1'b1, 1'b0, 1'b0, 32'h0c, 32'h0, 4'hf, 1'b1, 32'hcafe0033, 2'd0);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         err_count++;
      end
   endtask

   // holds the command until cp_ready is seen ahead of a rising edge
   task automatic send_command(input int i);
      logic accepted;
      cp_valid        = 1'b1;
      cp_data.data    = rows[i].data;
      cp_data.byteen  = rows[i].be;
      cp_data.addr    = rows[i].addr;
      cp_data.read    = rows[i].read;
      cp_data.write   = rows[i].write;
      cp_data.posted  = rows[i].posted;
      cp_data.src_id  = rows[i].src_id;
      cp_data.dest_id = rows[i].dest_id;
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge clk);
         accepted = cp_ready;
         if (accepted && rows[i].exp_resp) begin
            exp_q.push_back(i);
         end
         @(posedge clk);
      end
      #2;
      cp_valid = 1'b0;
   endtask

   // --------------------------------------------------------------------------
   // slave memory model
   // --------------------------------------------------------------------------
   // the bus is sampled at the falling edge, where every input has settled
   always begin
      logic           rd_hit;
      logic           wr_hit;
      logic [3:0]     word;
      pkt_pkg::be_t   be;
      pkt_pkg::data_t wdata;
      @(negedge clk);
      rd_hit = m0_read && !m0_waitrequest;
      wr_hit = m0_write && !m0_waitrequest;
      word   = m0_address[5:2];
      be     = m0_byteenable;
      wdata  = m0_writedata;
      if ((m0_read || m0_write) && cp_data.byteen == '0) begin
         $display("slave access raised for a command with no byte enables");
         err_count++;
      end
      @(posedge clk);
      slave_cycle++;
      if (wr_hit) begin
         for (int b = 0; b < `AGENT_BE_W; b++) begin
            if (be[b]) begin
               mem[word][b*`AGENT_SYMBOL_W +: `AGENT_SYMBOL_W] =
                  wdata[b*`AGENT_SYMBOL_W +: `AGENT_SYMBOL_W];
            end
         end
      end
      if (rd_hit) begin
         ret_data.push_back(mem[word]);
         // word 15 answers with SLVERR
         ret_status.push_back((word == 4'd15) ? 2'd2 : 2'd0);
         ret_due.push_back(slave_cycle + int'($urandom_range(3, 1)));
      end
      #2;
      m0_waitrequest = ($urandom_range(3) == 0);
      rp_ready       = mixed ? ($urandom_range(1) == 1) : 1'b1;
      if (ret_due.size() != 0 && ret_due[0] <= slave_cycle) begin
         m0_readdatavalid = 1'b1;
         m0_readdata      = ret_data.pop_front();
         m0_response      = ret_status.pop_front();
         void'(ret_due.pop_front());
      end else begin
         m0_readdatavalid = 1'b0;
         m0_readdata      = '0;
         m0_response      = '0;
      end
   end

   // responses are taken in order against the expected queue
   always @(negedge clk) begin
      int r;
      if (rp_valid && rp_ready) begin
         if (exp_q.size() == 0) begin
            $display("response arrived with no command waiting for one");
            err_count++;
         end else begin
            r = exp_q.pop_front();
            check_value({rows[r].name, " data"}, rows[r].exp_data, rp_data.data);
            check_value({rows[r].name, " status"}, 32'(rows[r].exp_status),
                        32'(rp_data.status));
            check_value({rows[r].name, " read"}, 32'(rows[r].read), 32'(rp_data.read));
            check_value({rows[r].name, " write"}, 32'(rows[r].write), 32'(rp_data.write));
            check_value({rows[r].name, " byteen"}, 32'(rows[r].be), 32'(rp_data.byteen));
            // ids come back swapped
            check_value({rows[r].name, " src_id"}, 32'(rows[r].dest_id), 32'(rp_data.src_id));
            check_value({rows[r].name, " dest_id"}, 32'(rows[r].src_id), 32'(rp_data.dest_id));
         end
      end
   end

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle > timeout_limit) begin
         $display("run stopped after %0d cycles, %0d responses never arrived",
                  cycle, exp_q.size());
         $display("TEST FAILED");
         $finish;
      end
   end

   // --------------------------------------------------------------------------
   // main sequence
   // --------------------------------------------------------------------------
   initial begin
      clk              = 1'b0;
      reset            = 1'b1;
      cp_valid         = 1'b0;
      cp_data          = '0;
      rp_ready         = 1'b1;
      m0_waitrequest   = 1'b0;
      m0_readdata      = '0;
      m0_readdatavalid = 1'b0;
      m0_response      = '0;
      mixed            = 1'b0;
      err_count        = 0;
      check_count      = 0;
      cycle            = 0;
      slave_cycle      = 0;
      void'($urandom(32'hf5a7c999));
      for (int w = 0; w < 16; w++) begin
         mem[w] = 32'hcafe0000 + w * 32'h11;
      end
      build_table();
      // each row gets 40 cycles on top of the reset phase
      timeout_limit = 40 * rows.size() + 8;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
      foreach (rows[i]) begin
         mixed = (i >= mixed_first);
         send_command(i);
      end
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      // a few idle cycles catch stray extra responses
      repeat (10) @(posedge clk);
      $display("checks %0d, value and protocol errors %0d, assertion failures %0d",
               check_count, err_count, UUT.checker_inst.fail_count);
      if (err_count + UUT.checker_inst.fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* source/sync_fifo.sv */
// synchronous circular-buffer queue with a type-parameter entry
`timescale 1ns/100ps

module sync_fifo #(
   parameter type entry_t = logic [7:0],
   parameter int  depth   = 4
) (
   input  logic   clk,
   input  logic   reset,
   input  logic   push,
   input  entry_t push_data,
   input  logic   pop,
   output entry_t pop_data,
   output logic   empty,
   output logic   full
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);
   localparam logic [ptr_w:0]   full_count = (ptr_w + 1)'(depth);

   entry_t           mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             do_push;
   logic             do_pop;

   // a push into a full queue or a pop from an empty one is dropped
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign empty    = (count == '0);
   assign full     = (count == full_count);
   assign pop_data = mem[rd_ptr];

   // storage is written only, the pointers say which slots hold live data
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // --------------------------------------------------------------------------
   // pointers and occupancy
   // --------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
         end
         // count moves only when exactly one side is active
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* vlog.f */
+incdir+common
common/slave_pkg.sv
common/pkt_pkg.sv
source/sync_fifo.sv
agent/cmd_decode.sv
agent/cmd_execute.sv
agent/resp_result.sv
agent/slave_agent.sv
sim/slave_agent_checker.sv
sim/slave_agent_tb.sv
